// ==== hw/rvExec_macros.svh ====
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// datapath width
////////////////////////////////////////////////////////////////////////////

`define RV_XLEN 32

////////////////////////////////////////////////////////////////////////////
// RV32I major opcodes
////////////////////////////////////////////////////////////////////////////

`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011

////////////////////////////////////////////////////////////////////////////
// APB register map, byte offsets
////////////////////////////////////////////////////////////////////////////

// bit 0 is enable, bit 1 clears the statistics when written with 1.
`define REG_CTRL    8'h00
`define REG_RETIRED 8'h04
`define REG_TAKEN   8'h08
`define REG_ILLEGAL 8'h0C
`define REG_LASTBAD 8'h10

`endif

// ==== hw/rvExecPkg.sv ====
`include "rvExec_macros.svh"

package rvExecPkg;

    // the ALU operation codes take five bits.
    typedef enum logic [4:0] {
        IDLE,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } aluOp_t;

    // contents of the decode slot.
    typedef struct packed {
        aluOp_t                aluOp;
        logic [`RV_XLEN-1:0]   imm;
        logic                  useImm;
        logic                  usePc;
        logic                  link;
        logic                  illegal;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   rs1Val;
        logic [`RV_XLEN-1:0]   rs2Val;
        logic [31:0]           instr;
    } decoded_t;

    // contents of the result slot.
    // the instruction word rides along so the statistics can keep the last bad one.
    typedef struct packed {
        logic [`RV_XLEN-1:0]   result;
        logic                  taken;
        logic                  illegal;
        logic [31:0]           instr;
    } result_t;

endpackage

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ps
`include "rvExec_macros.svh"

module instrDecoder (
    input  logic [31:0]       instr,
    output rvExecPkg::aluOp_t aluOp,
    output logic [31:0]       imm,
    output logic              useImm,
    output logic              usePc,
    output logic              link,
    output logic              illegal
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] iImm;
    logic [31:0] sImm;
    logic [31:0] bImm;
    logic [31:0] uImm;
    logic [31:0] jImm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign iImm = {{20{instr[31]}}, instr[31:20]};
    assign sImm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign bImm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign uImm = {instr[31:12], 12'b0};
    assign jImm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 order shared by OP and OP_IMM.
    function automatic rvExecPkg::aluOp_t arithOp(input logic [2:0] f3, input logic arith);
        case (f3)
            3'b000:  arithOp = rvExecPkg::ADD;
            3'b001:  arithOp = rvExecPkg::SLL;
            3'b010:  arithOp = rvExecPkg::SLT;
            3'b011:  arithOp = rvExecPkg::SLTU;
            3'b100:  arithOp = rvExecPkg::XOR;
            3'b101:  arithOp = arith ? rvExecPkg::SRA : rvExecPkg::SRL;
            3'b110:  arithOp = rvExecPkg::OR;
            default: arithOp = rvExecPkg::AND;
        endcase
    endfunction

    always_comb begin
        aluOp   = rvExecPkg::IDLE;
        imm     = '0;
        useImm  = 1'b0;
        usePc   = 1'b0;
        link    = 1'b0;
        illegal = 1'b0;
        case (opcode)
            // IDLE hands operand B straight through, which gives LUI its result.
            `OPC_LUI: begin
                imm    = uImm;
                useImm = 1'b1;
            end
            `OPC_AUIPC: begin
                aluOp  = rvExecPkg::ADD;
                imm    = uImm;
                useImm = 1'b1;
                usePc  = 1'b1;
            end
            `OPC_JAL: begin
                imm  = jImm;
                link = 1'b1;
            end
            `OPC_JALR: begin
                aluOp  = rvExecPkg::ADD;
                imm    = iImm;
                useImm = 1'b1;
                link   = 1'b1;
            end
            `OPC_BRANCH: begin
                imm = bImm;
                case (funct3)
                    3'b000:  aluOp = rvExecPkg::BEQ;
                    3'b001:  aluOp = rvExecPkg::BNE;
                    3'b100:  aluOp = rvExecPkg::BLT;
                    3'b101:  aluOp = rvExecPkg::BGE;
                    3'b110:  aluOp = rvExecPkg::BLTU;
                    3'b111:  aluOp = rvExecPkg::BGEU;
                    default: illegal = 1'b1;
                endcase
            end
            `OPC_LOAD, `OPC_STORE: begin
                aluOp  = rvExecPkg::ADD;
                imm    = (opcode == `OPC_STORE) ? sImm : iImm;
                useImm = 1'b1;
            end
            `OPC_OP_IMM: begin
                // bit 30 only matters for the right shift, where it picks SRAI.
                aluOp  = arithOp(funct3, instr[30]);
                imm    = iImm;
                useImm = 1'b1;
            end
            `OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    aluOp = arithOp(funct3, 1'b0);
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    aluOp = rvExecPkg::SUB;
                end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
                    aluOp = rvExecPkg::SRA;
                end else begin
                    illegal = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// ==== hw/aluCore.sv ====
`timescale 1ns/1ps
`include "rvExec_macros.svh"

module aluCore (
    input  rvExecPkg::decoded_t op,
    output rvExecPkg::result_t  res
);

    localparam int W = `RV_XLEN;

    logic [W-1:0] opA;
    logic [W-1:0] opB;
    logic [4:0]   shamt;
    logic [W-1:0] value;
    logic         cond;

    assign opA   = op.usePc ? op.pc : op.rs1Val;
    assign opB   = op.useImm ? op.imm : op.rs2Val;
    assign shamt = opB[4:0];

    always_comb begin
        value = '0;
        cond  = 1'b0;
        case (op.aluOp)
            rvExecPkg::IDLE: value = opB;
            rvExecPkg::ADD:  value = opA + opB;
            rvExecPkg::SUB:  value = opA - opB;
            rvExecPkg::SLL:  value = opA << shamt;
            rvExecPkg::SLT:  value = {{(W-1){1'b0}}, $signed(opA) < $signed(opB)};
            rvExecPkg::SLTU: value = {{(W-1){1'b0}}, opA < opB};
            rvExecPkg::XOR:  value = opA ^ opB;
            rvExecPkg::SRL:  value = opA >> shamt;
            rvExecPkg::SRA:  value = $signed(opA) >>> shamt;
            rvExecPkg::OR:   value = opA | opB;
            rvExecPkg::AND:  value = opA & opB;
            rvExecPkg::BEQ:  cond = (opA == opB);
            rvExecPkg::BNE:  cond = (opA != opB);
            rvExecPkg::BLT:  cond = ($signed(opA) < $signed(opB));
            rvExecPkg::BGE:  cond = ($signed(opA) >= $signed(opB));
            rvExecPkg::BLTU: cond = (opA < opB);
            rvExecPkg::BGEU: cond = (opA >= opB);
            default:         value = '0;
        endcase

        // jumps write the return address and always count as taken.
        if (op.link) begin
            value = op.pc + W'(4);
            cond  = 1'b1;
        end

        if (op.illegal) begin
            value = '0;
            cond  = 1'b0;
        end
    end

    assign res.result  = value;
    assign res.taken   = cond;
    assign res.illegal = op.illegal;
    assign res.instr   = op.instr;

endmodule

// ==== hw/pipeSlot.sv ====
`timescale 1ns/1ps

module pipeSlot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     inValid,
    input  payload_t inData,
    output logic     inReady,
    output logic     outValid,
    output payload_t outData,
    input  logic     outReady
);

    // the slot takes new data when it is empty or is being emptied this cycle.
    assign inReady = outReady || !outValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            outData <= inData;
        end
    end

endmodule

// ==== hw/execRegs.sv ====
`timescale 1ns/1ps
`include "rvExec_macros.svh"

module execRegs (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        enable,
    input  logic        retire,
    input  logic        retireTaken,
    input  logic        retireIllegal,
    input  logic [31:0] retireInstr
);

    logic        access;
    logic        wrCtrl;
    logic        clearStats;
    logic        unmapped;
    logic        readOnly;
    logic [31:0] rdData;
    logic [31:0] retiredCnt;
    logic [31:0] takenCnt;
    logic [31:0] illegalCnt;
    logic [31:0] lastBad;

    assign access     = psel && penable;
    assign wrCtrl     = access && pwrite && (paddr == `REG_CTRL);
    assign clearStats = wrCtrl && pwdata[1];

    // no wait states.
    assign pready = 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // read decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rdData   = '0;
        unmapped = 1'b0;
        readOnly = 1'b1;
        case (paddr)
            `REG_CTRL: begin
                rdData   = {31'b0, enable};
                readOnly = 1'b0;
            end
            `REG_RETIRED: rdData = retiredCnt;
            `REG_TAKEN:   rdData = takenCnt;
            `REG_ILLEGAL: rdData = illegalCnt;
            `REG_LASTBAD: rdData = lastBad;
            default:      unmapped = 1'b1;
        endcase
    end

    assign prdata  = (access && !pwrite) ? rdData : '0;
    assign pslverr = access && (unmapped || (pwrite && readOnly));

    ////////////////////////////////////////////////////////////////////////////
    // control and statistics
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
        end else if (wrCtrl) begin
            enable <= pwdata[0];
        end
    end

    // a clear in the same cycle as a retirement wins.
    always_ff @(posedge clk) begin
        if (rst || clearStats) begin
            retiredCnt <= '0;
            takenCnt   <= '0;
            illegalCnt <= '0;
            lastBad    <= '0;
        end else if (retire) begin
            retiredCnt <= retiredCnt + 32'd1;
            if (retireTaken) begin
                takenCnt <= takenCnt + 32'd1;
            end
            if (retireIllegal) begin
                illegalCnt <= illegalCnt + 32'd1;
                lastBad    <= retireInstr;
            end
        end
    end

endmodule

// ==== hw/rvExecTop.sv ====
`timescale 1ns/1ps
`include "rvExec_macros.svh"

module rvExecTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                inValid,
    output logic                inReady,
    input  logic [31:0]         instr,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rs1Val,
    input  logic [`RV_XLEN-1:0] rs2Val,
    output logic                outValid,
    input  logic                outReady,
    output logic [`RV_XLEN-1:0] result,
    output logic                taken,
    output logic                illegal,
    input  logic [7:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr
);

    rvExecPkg::aluOp_t   decAluOp;
    logic [31:0]         decImm;
    logic                decUseImm;
    logic                decUsePc;
    logic                decLink;
    logic                decIllegal;
    rvExecPkg::decoded_t decIn;
    rvExecPkg::decoded_t decOut;
    logic                decReady;
    logic                decValid;
    rvExecPkg::result_t  aluRes;
    rvExecPkg::result_t  resOut;
    logic                resReady;
    logic                enable;

    instrDecoder i_instrDecoder (
        .instr   (instr),
        .aluOp   (decAluOp),
        .imm     (decImm),
        .useImm  (decUseImm),
        .usePc   (decUsePc),
        .link    (decLink),
        .illegal (decIllegal)
    );

    assign decIn = '{aluOp: decAluOp, imm: decImm, useImm: decUseImm, usePc: decUsePc,
                     link: decLink, illegal: decIllegal, pc: pc, rs1Val: rs1Val,
                     rs2Val: rs2Val, instr: instr};

    // with the datapath disabled nothing new enters, but the slots still drain.
    assign inReady = enable && decReady;

    pipeSlot #(.payload_t(rvExecPkg::decoded_t)) i_slotDecode (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid && enable),
        .inData   (decIn),
        .inReady  (decReady),
        .outValid (decValid),
        .outData  (decOut),
        .outReady (resReady)
    );

    aluCore i_aluCore (
        .op  (decOut),
        .res (aluRes)
    );

    pipeSlot #(.payload_t(rvExecPkg::result_t)) i_slotResult (
        .clk      (clk),
        .rst      (rst),
        .inValid  (decValid),
        .inData   (aluRes),
        .inReady  (resReady),
        .outValid (outValid),
        .outData  (resOut),
        .outReady (outReady)
    );

    assign result  = resOut.result;
    assign taken   = resOut.taken;
    assign illegal = resOut.illegal;

    execRegs i_execRegs (
        .clk           (clk),
        .rst           (rst),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .enable        (enable),
        .retire        (outValid && outReady),
        .retireTaken   (resOut.taken),
        .retireIllegal (resOut.illegal),
        .retireInstr   (resOut.instr)
    );

endmodule

// ==== tb/rvExec_asserts.sv ====
`timescale 1ns/1ps

module rvExecAsserts (
    input logic        clk,
    input logic        rst,
    input logic        enable,
    input logic        inReady,
    input logic        outValid,
    input logic        outReady,
    input logic [31:0] result,
    input logic        taken,
    input logic        illegal,
    input logic        psel,
    input logic        penable,
    input logic        pslverr
);

    int failCount = 0;

    // a stalled result must not change until it is taken.
    property outputHolds;
        @(posedge clk) disable iff (rst)
        (outValid && !outReady) |=>
            (outValid && $stable(result) && $stable(taken) && $stable(illegal));
    endproperty

    property noInputWhenDisabled;
        @(posedge clk) disable iff (rst)
        !enable |-> !inReady;
    endproperty

    property errorOnlyInAccess;
        @(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable);
    endproperty

    aOutputHolds: assert property (outputHolds) else begin
        failCount++;
        $error("output stream changed while outValid was high and outReady low");
    end

    aNoInputWhenDisabled: assert property (noInputWhenDisabled) else begin
        failCount++;
        $error("inReady high while the datapath is disabled");
    end

    aErrorOnlyInAccess: assert property (errorOnlyInAccess) else begin
        failCount++;
        $error("pslverr high outside an APB access phase");
    end

endmodule

bind rvExecTop rvExecAsserts i_rvExecAsserts (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .result   (result),
    .taken    (taken),
    .illegal  (illegal),
    .psel     (psel),
    .penable  (penable),
    .pslverr  (pslverr)
);

// ==== tb/rvExecTb.sv ====
`timescale 1ns/1ps
`include "rvExec_macros.svh"

module rvExecTb;

    localparam int TIMEOUT = 200;

    logic                clk = 1'b0;
    logic                rst;
    logic                inValid;
    logic                inReady;
    logic [31:0]         instr;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1Val;
    logic [`RV_XLEN-1:0] rs2Val;
    logic                outValid;
    logic                outReady;
    logic [`RV_XLEN-1:0] result;
    logic                taken;
    logic                illegal;
    logic [7:0]          paddr;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;

    // one entry per golden line, in the order the results must leave.
    logic [31:0] goldInstr[$];
    logic [31:0] goldPc[$];
    logic [31:0] goldRs1[$];
    logic [31:0] goldRs2[$];
    logic [31:0] goldResult[$];
    logic        goldTaken[$];
    logic        goldIllegal[$];
    int          expTaken = 0;
    int          expIllegal = 0;
    logic [31:0] expLastBad = '0;

    always #50 clk = ~clk;

    rvExecTop i_rvExecTop (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .instr    (instr),
        .pc       (pc),
        .rs1Val   (rs1Val),
        .rs2Val   (rs2Val),
        .outValid (outValid),
        .outReady (outReady),
        .result   (result),
        .taken    (taken),
        .illegal  (illegal),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            stopOnError($sformatf("FAIL %s: got 0x%08h, expected 0x%08h",
                                  name, actual, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // golden file
    ////////////////////////////////////////////////////////////////////////////

    task automatic loadGolden();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] f [7];
        fd = $fopen("tb/rvExec_golden.txt", "r");
        if (fd == 0) begin
            stopOnError("could not open tb/rvExec_golden.txt for reading");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 8 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h",
                             f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            if (fields != 7) begin
                stopOnError($sformatf("malformed golden line: %s", line));
            end
            goldInstr.push_back(f[0]);
            goldPc.push_back(f[1]);
            goldRs1.push_back(f[2]);
            goldRs2.push_back(f[3]);
            goldResult.push_back(f[4]);
            goldTaken.push_back(f[5][0]);
            goldIllegal.push_back(f[6][0]);
            if (f[5][0]) begin
                expTaken++;
            end
            if (f[6][0]) begin
                expIllegal++;
                expLastBad = f[0];
            end
        end
        $fclose(fd);
        if (goldInstr.size() == 0) begin
            stopOnError("the golden file holds no instructions");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////////////////////

    task automatic apbAccess(input logic [7:0] addr, input logic write,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
        int t;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        t = 0;
        @(negedge clk);
        while (!pready) begin
            t++;
            if (t > TIMEOUT) begin
                stopOnError("timed out waiting for pready in an APB access phase");
            end
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        // the transfer completes at this edge.
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic regRead(input logic [7:0] addr, input string name,
                           input logic [31:0] expected);
        logic [31:0] data;
        logic        err;
        apbAccess(addr, 1'b0, '0, data, err);
        checkValue(name, data, expected);
        checkValue({name, " pslverr"}, err, 1'b0);
    endtask

    task automatic regWrite(input logic [7:0] addr, input logic [31:0] data,
                            input string name);
        logic [31:0] unused;
        logic        err;
        apbAccess(addr, 1'b1, data, unused, err);
        checkValue({name, " write pslverr"}, err, 1'b0);
    endtask

    task automatic checkStats();
        regRead(`REG_RETIRED, "RETIRED", goldInstr.size());
        regRead(`REG_TAKEN, "TAKEN", expTaken);
        regRead(`REG_ILLEGAL, "ILLEGAL", expIllegal);
        regRead(`REG_LASTBAD, "LASTBAD", expLastBad);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // instruction stream
    ////////////////////////////////////////////////////////////////////////////

    task automatic offerFirst(input logic valid);
        @(posedge clk);
        inValid <= valid;
        instr   <= goldInstr[0];
        pc      <= goldPc[0];
        rs1Val  <= goldRs1[0];
        rs2Val  <= goldRs2[0];
    endtask

    task automatic checkDisabled();
        int i;
        offerFirst(1'b1);
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            checkValue("inReady while disabled", inReady, 1'b0);
            checkValue("outValid while disabled", outValid, 1'b0);
        end
        offerFirst(1'b0);
    endtask

    task automatic driveInstrs(input bit stall);
        int i;
        int t;
        for (i = 0; i < goldInstr.size(); i++) begin
            if (stall && $urandom_range(0, 3) == 0) begin
                @(posedge clk);
                inValid <= 1'b0;
            end
            @(posedge clk);
            inValid <= 1'b1;
            instr   <= goldInstr[i];
            pc      <= goldPc[i];
            rs1Val  <= goldRs1[i];
            rs2Val  <= goldRs2[i];
            t = 0;
            @(negedge clk);
            while (!inReady) begin
                t++;
                if (t > TIMEOUT) begin
                    stopOnError($sformatf("timed out waiting for inReady, instruction %0d", i));
                end
                @(negedge clk);
            end
        end
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    task automatic collectResults(input bit stall);
        int k;
        int idle;
        k = 0;
        idle = 0;
        while (k < goldInstr.size()) begin
            @(posedge clk);
            outReady <= stall ? ($urandom_range(0, 2) != 0) : 1'b1;
            @(negedge clk);
            if (outValid && outReady) begin
                checkValue($sformatf("result[%0d]", k), result, goldResult[k]);
                checkValue($sformatf("taken[%0d]", k), taken, goldTaken[k]);
                checkValue($sformatf("illegal[%0d]", k), illegal, goldIllegal[k]);
                k++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    stopOnError($sformatf("timed out waiting for result %0d", k));
                end
            end
        end
        @(posedge clk);
        outReady <= 1'b0;
        @(negedge clk);
        checkValue("outValid after the last result", outValid, 1'b0);
    endtask

    task automatic runStream(input bit stall);
        fork
            driveInstrs(stall);
            collectResults(stall);
        join
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          seedInit;
        logic [31:0] data;
        logic        err;
        seedInit = $urandom(51);
        rst      <= 1'b1;
        inValid  <= 1'b0;
        instr    <= '0;
        pc       <= '0;
        rs1Val   <= '0;
        rs2Val   <= '0;
        outReady <= 1'b0;
        paddr    <= '0;
        psel     <= 1'b0;
        penable  <= 1'b0;
        pwrite   <= 1'b0;
        pwdata   <= '0;
        loadGolden();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        regRead(`REG_CTRL, "CTRL after reset", 32'd0);
        regRead(`REG_RETIRED, "RETIRED after reset", 32'd0);
        regRead(`REG_TAKEN, "TAKEN after reset", 32'd0);
        regRead(`REG_ILLEGAL, "ILLEGAL after reset", 32'd0);
        regRead(`REG_LASTBAD, "LASTBAD after reset", 32'd0);
        checkDisabled();

        regWrite(`REG_CTRL, 32'h1, "CTRL");
        regRead(`REG_CTRL, "CTRL enabled", 32'h1);
        runStream(1'b0);
        checkStats();

        // clear the statistics and keep the datapath enabled.
        regWrite(`REG_CTRL, 32'h3, "CTRL");
        regRead(`REG_CTRL, "CTRL after clear", 32'h1);
        regRead(`REG_RETIRED, "RETIRED after clear", 32'd0);
        regRead(`REG_TAKEN, "TAKEN after clear", 32'd0);
        regRead(`REG_ILLEGAL, "ILLEGAL after clear", 32'd0);
        regRead(`REG_LASTBAD, "LASTBAD after clear", 32'd0);

        runStream(1'b1);
        checkStats();

        apbAccess(8'h14, 1'b0, '0, data, err);
        checkValue("pslverr on read of 0x14", err, 1'b1);
        apbAccess(8'h14, 1'b1, 32'h1, data, err);
        checkValue("pslverr on write of 0x14", err, 1'b1);
        apbAccess(`REG_RETIRED, 1'b1, 32'h0, data, err);
        checkValue("pslverr on write of RETIRED", err, 1'b1);
        regRead(`REG_RETIRED, "RETIRED after rejected write", goldInstr.size());

        if (i_rvExecTop.i_rvExecAsserts.failCount == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            stopOnError($sformatf("%0d protocol assertion failures",
                                  i_rvExecTop.i_rvExecAsserts.failCount));
        end
    end

endmodule

// ==== tb/rvExec_golden.txt ====
# instr    pc       rs1Val   rs2Val   result   taken illegal, all hex, then the mnemonic
# results leave the DUT in the order of the lines
123450B7 00001000 00000000 00000000 12345000 0 0 lui
00001097 00001004 00000000 00000000 00002004 0 0 auipc
003100B3 00001008 00000005 00000007 0000000C 0 0 add
403100B3 0000100C 00000005 00000007 FFFFFFFE 0 0 sub
003110B3 00001010 00000001 00000024 00000010 0 0 sll
003120B3 00001014 FFFFFFFF 00000001 00000001 0 0 slt
003130B3 00001018 FFFFFFFF 00000001 00000000 0 0 sltu
003140B3 0000101C F0F0F0F0 FF00FF00 0FF00FF0 0 0 xor
003150B3 00001020 80000000 00000004 08000000 0 0 srl
403150B3 00001024 80000000 00000004 F8000000 0 0 sra
003160B3 00001028 0000F000 0000000F 0000F00F 0 0 or
003170B3 0000102C 12345678 0000FFFF 00005678 0 0 and
0000007F 00001030 00000001 00000002 00000000 0 1 unknown opcode
FFF10093 00001034 0000000A 00000055 00000009 0 0 addi
00512093 00001038 FFFFFFFB 00000000 00000001 0 0 slti
FFF13093 0000103C 00000005 00000000 00000001 0 0 sltiu
0FF14093 00001040 0000F0F0 00000000 0000F00F 0 0 xori
00311093 00001044 00000011 00000000 00000088 0 0 slli
00815093 00001048 80000000 00000000 00800000 0 0 srli
40815093 0000104C 80000000 00000000 FF800000 0 0 srai
70016093 00001050 0000000F 00000000 0000070F 0 0 ori
0F017093 00001054 12345678 00000000 00000070 0 0 andi
000000EF 00001058 00000000 00000000 0000105C 1 0 jal
000100E7 0000105C 00002000 00000000 00001060 1 0 jalr
00310063 00001060 00000005 00000005 00000000 1 0 beq
00311063 00001064 00000005 00000005 00000000 0 0 bne
00314063 00001068 FFFFFFFF 00000001 00000000 1 0 blt
00315063 0000106C FFFFFFFF 00000001 00000000 0 0 bge
00316063 00001070 FFFFFFFF 00000001 00000000 0 0 bltu
00317063 00001074 FFFFFFFF 00000001 00000000 1 0 bgeu
00312063 00001078 00000001 00000002 00000000 0 1 branch funct3 010
00812083 0000107C 00001000 00000000 00001008 0 0 lw
FE312E23 00001080 00001000 DEADBEEF 00000FFC 0 0 sw
023100B3 00001084 00000006 00000007 00000000 0 1 op funct7 0000001
403110B3 00001088 00000001 00000002 00000000 0 1 op funct7 0100000 funct3 001

// ==== filelist.f ====
+incdir+hw
hw/rvExecPkg.sv
hw/instrDecoder.sv
hw/aluCore.sv
hw/pipeSlot.sv
hw/execRegs.sv
hw/rvExecTop.sv
tb/rvExec_asserts.sv
tb/rvExecTb.sv
